// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f compile.f --top-module tb_trace_mon -Mdir obj_dir
	./obj_dir/Vtb_trace_mon | tee sim.log
	grep -q "^Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/trace_pkg.sv
package trace_pkg;

  // Largest supported core count, sets the width of the event core field
  localparam int MAX_CORES = 16;
  localparam int CORE_W    = $clog2(MAX_CORES);

  // Argument register of the simulation no-ops
  localparam logic [4:0] ARG_REG = 5'd3;

  // Simulation control no-op instruction words
  localparam logic [31:0] NOP_EXIT   = 32'h15000001;
  localparam logic [31:0] NOP_REPORT = 32'h15000002;
  localparam logic [31:0] NOP_PUTC   = 32'h15000004;

  // One retired instruction as delivered by a core
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        wben;
    logic [4:0]  wbreg;
    logic [31:0] wbdata;
  } trace_exec_t;

  // Kind of a simulation control event
  typedef enum logic [1:0] {
    EV_EXIT,
    EV_REPORT,
    EV_PUTC
  } ev_kind_e;

  // Event handed to the host
  typedef struct packed {
    logic [CORE_W-1:0] core;
    ev_kind_e          kind;
    logic [31:0]       value;
  } trace_event_t;

endpackage

// File: compile.f
common/trace_pkg.sv
trace_decode/trace_decode.sv
src/event_fifo.sv
src/event_arbiter.sv
src/host_link.sv
src/trace_mon_top.sv
testbench/tb_trace_mon.sv

// File: src/event_arbiter.sv
module event_arbiter #(
  parameter int NUM_CORES = 4
) (
  input  logic                                    clk,
  input  logic                                    rst_i,
  input  logic [NUM_CORES-1:0]                    nonempty_i,
  input  trace_pkg::trace_event_t [NUM_CORES-1:0] head_i,
  output logic [NUM_CORES-1:0]                    pop_o,
  input  logic                                    link_idle_i,
  output logic                                    load_o,
  output trace_pkg::trace_event_t                 load_event_o
);

  localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

  logic [IDX_W-1:0] last_q;
  logic [IDX_W-1:0] sel;
  logic             found;

  // Scan the queues starting just after the last granted one
  always_comb begin
    int cand;
    found = 1'b0;
    sel   = last_q;
    cand  = 0;
    for (int off = 1; off <= NUM_CORES; off++) begin
      cand = (int'(last_q) + off) % NUM_CORES;
      if (!found && nonempty_i[cand]) begin
        found = 1'b1;
        sel   = IDX_W'(cand);
      end
    end
  end

  assign load_o       = link_idle_i && found;
  assign load_event_o = head_i[sel];

  // Pop and load happen in the same cycle
  always_comb begin
    pop_o = '0;
    if (load_o) begin
      pop_o[sel] = 1'b1;
    end
  end

  // Start so that core 0 has priority after reset
  always_ff @(posedge clk) begin
    if (rst_i) begin
      last_q <= IDX_W'(NUM_CORES - 1);
    end else if (load_o) begin
      last_q <= sel;
    end
  end

endmodule

// File: src/event_fifo.sv
module event_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    push_i,
  input  trace_pkg::trace_event_t push_event_i,
  input  logic                    pop_i,
  output trace_pkg::trace_event_t head_o,
  output logic                    nonempty_o,
  output logic                    overflow_o
);

  import trace_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  trace_event_t     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic             full;
  logic             do_pop;
  logic             do_push;

  assign full       = (count_q == CNT_W'(FIFO_DEPTH));
  assign nonempty_o = (count_q != '0);
  assign head_o     = mem[rd_ptr_q];

  assign do_pop  = pop_i && nonempty_o;
  // A slot freed by a pop in the same cycle may be reused
  assign do_push = push_i && (!full || do_pop);

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    next_ptr = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
      // Sticky until reset
      if (push_i && !do_push) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_event_i;
    end
  end

endmodule

// File: src/host_link.sv
module host_link #(
  parameter int NUM_CORES = 4
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    load_i,
  input  trace_pkg::trace_event_t load_event_i,
  output logic                    idle_o,
  output logic                    host_req_o,
  input  logic                    host_ack_i,
  output trace_pkg::trace_event_t host_event_o,
  output logic                    done_o
);

  import trace_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_RELEASE
  } link_state_e;

  link_state_e          state_q;
  trace_event_t         event_q;
  logic [NUM_CORES-1:0] exit_mask_q;
  logic [NUM_CORES-1:0] core_bit;
  logic                 xfer_done;

  assign idle_o       = (state_q == IDLE);
  assign host_req_o   = (state_q == REQ);
  assign host_event_o = event_q;
  assign done_o       = &exit_mask_q;

  // Four-phase transfer ends once ack is seen low again
  assign xfer_done = (state_q == WAIT_RELEASE) && !host_ack_i;

  // One-hot of the core that owns the event in flight
  always_comb begin
    core_bit = '0;
    for (int c = 0; c < NUM_CORES; c++) begin
      if (event_q.core == CORE_W'(c)) begin
        core_bit[c] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= IDLE;
      exit_mask_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (load_i) begin
            state_q <= REQ;
          end
        end
        REQ: begin
          if (host_ack_i) begin
            state_q <= WAIT_RELEASE;
          end
        end
        WAIT_RELEASE: begin
          if (!host_ack_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
      if (xfer_done && (event_q.kind == EV_EXIT)) begin
        exit_mask_q <= exit_mask_q | core_bit;
      end
    end
  end

  // Only loaded while idle, so it holds through the whole transfer
  always_ff @(posedge clk) begin
    if (idle_o && load_i) begin
      event_q <= load_event_i;
    end
  end

endmodule

// File: src/trace_mon_top.sv
module trace_mon_top #(
  parameter int NUM_CORES  = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                   clk,
  input  logic                                   rst_i,
  input  trace_pkg::trace_exec_t [NUM_CORES-1:0] trace_i,
  input  logic                                   host_ack_i,
  output logic                                   host_req_o,
  output trace_pkg::trace_event_t                host_event_o,
  output logic                                   done_o,
  output logic [NUM_CORES-1:0]                   overflow_o
);

  import trace_pkg::*;

  logic         [NUM_CORES-1:0] ev_valid;
  trace_event_t [NUM_CORES-1:0] ev;
  logic         [NUM_CORES-1:0] nonempty;
  trace_event_t [NUM_CORES-1:0] head;
  logic         [NUM_CORES-1:0] pop;

  logic         load;
  trace_event_t load_event;
  logic         link_idle;

  // One decoder and one queue per core
  for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core
    trace_decode u_decode (
      .clk        (clk),
      .rst_i      (rst_i),
      .core_id_i  (CORE_W'(c)),
      .trace_i    (trace_i[c]),
      .ev_valid_o (ev_valid[c]),
      .ev_o       (ev[c])
    );

    event_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_i       (ev_valid[c]),
      .push_event_i (ev[c]),
      .pop_i        (pop[c]),
      .head_o       (head[c]),
      .nonempty_o   (nonempty[c]),
      .overflow_o   (overflow_o[c])
    );
  end

  event_arbiter #(
    .NUM_CORES (NUM_CORES)
  ) u_arbiter (
    .clk          (clk),
    .rst_i        (rst_i),
    .nonempty_i   (nonempty),
    .head_i       (head),
    .pop_o        (pop),
    .link_idle_i  (link_idle),
    .load_o       (load),
    .load_event_o (load_event)
  );

  host_link #(
    .NUM_CORES (NUM_CORES)
  ) u_link (
    .clk          (clk),
    .rst_i        (rst_i),
    .load_i       (load),
    .load_event_i (load_event),
    .idle_o       (link_idle),
    .host_req_o   (host_req_o),
    .host_ack_i   (host_ack_i),
    .host_event_o (host_event_o),
    .done_o       (done_o)
  );

endmodule

// File: testbench/tb_trace_mon.sv
module tb_trace_mon;

  timeunit 1ns;
  timeprecision 100ps;

  import trace_pkg::*;

  localparam int NUM_CORES    = 4;
  localparam int FIFO_DEPTH   = 4;
  localparam int REC_PER_CORE = 40;
  localparam int POST_EXIT    = 5;
  localparam int RECS_TOTAL   = REC_PER_CORE + 1 + POST_EXIT;
  localparam int OVF_REPORTS  = FIFO_DEPTH + 3;
  localparam int NUM_RECORDS  = NUM_CORES * RECS_TOTAL + 2 * OVF_REPORTS;
  localparam int CYCLE_LIMIT  = 200 * NUM_RECORDS + 2000;

  logic                          clk;
  logic                          rst_i;
  trace_exec_t [NUM_CORES-1:0]   trace_i;
  logic                          host_ack_i;
  logic                          host_req_o;
  trace_event_t                  host_event_o;
  logic                          done_o;
  logic [NUM_CORES-1:0]          overflow_o;

  integer       seed = 32'hb7ac7b07;
  int           checks;
  int           errors;
  int           errors_before;
  int           events_seen;
  int           exits_rcvd;
  int           cycles;
  int           next_idx [NUM_CORES];
  logic [31:0]  r3_model [NUM_CORES];
  logic         halted [NUM_CORES];
  trace_event_t exp_q [NUM_CORES][$];
  logic         ack_enable;
  logic         req_q;
  logic         done_q;
  trace_event_t event_q;
  trace_exec_t  rec;
  logic [31:0]  tmp;

  trace_mon_top #(
    .NUM_CORES  (NUM_CORES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .clk          (clk),
    .rst_i        (rst_i),
    .trace_i      (trace_i),
    .host_ack_i   (host_ack_i),
    .host_req_o   (host_req_o),
    .host_event_o (host_event_o),
    .done_o       (done_o),
    .overflow_o   (overflow_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic build_record(input logic is_exit, input int nop_pct,
                              output trace_exec_t r);
    int pick;
    r.valid = 1'b1;
    r.pc    = $random(seed);
    pick    = $unsigned($random(seed)) % 100;
    if (is_exit) begin
      r.insn = NOP_EXIT;
    end else if (pick < nop_pct) begin
      r.insn = (pick % 2 == 0) ? NOP_REPORT : NOP_PUTC;
    end else begin
      // Top byte keeps ordinary words clear of the no-op encodings
      r.insn = {8'h13, 24'($random(seed))};
    end
    pick     = $unsigned($random(seed)) % 4;
    r.wben   = (pick != 1);
    r.wbreg  = 5'($random(seed));
    r.wbdata = $random(seed);
    if (pick == 0) begin
      r.wbreg = ARG_REG;
    end else if (r.wbreg == ARG_REG) begin
      r.wbreg = 5'd4;
    end
  endtask

  // Reference behavior of one core for one retired record
  task automatic model_record(input int c, input trace_exec_t r);
    trace_event_t ev;
    ev.core  = CORE_W'(c);
    ev.kind  = EV_REPORT;
    ev.value = r3_model[c];
    if (!halted[c]) begin
      case (r.insn)
        NOP_EXIT: begin
          ev.kind   = EV_EXIT;
          halted[c] = 1'b1;
          exp_q[c].push_back(ev);
        end
        NOP_REPORT: exp_q[c].push_back(ev);
        NOP_PUTC: begin
          ev.kind  = EV_PUTC;
          ev.value = {24'h0, r3_model[c][7:0]};
          exp_q[c].push_back(ev);
        end
        default: ;
      endcase
      if (r.wben && (r.wbreg == ARG_REG)) begin
        r3_model[c] = r.wbdata;
      end
    end
  endtask

  task automatic check_event(input trace_event_t got);
    trace_event_t exp;
    int c;
    c = int'(got.core);
    checks++;
    events_seen++;
    if (c >= NUM_CORES) begin
      $display("Event at %0t names core %0d, which does not exist", $time, c);
      errors++;
    end else if (exp_q[c].size() == 0) begin
      $display("Unexpected extra event at %0t from core %0d, kind %0d", $time, c, got.kind);
      errors++;
    end else begin
      exp = exp_q[c].pop_front();
      if (got.kind != exp.kind) begin
        $display("Fail at %0t: host_event_o.kind core %0d expected %0d got %0d",
                 $time, c, exp.kind, got.kind);
        errors++;
      end
      if (got.value != exp.value) begin
        $display("Fail at %0t: host_event_o.value core %0d expected %h got %h",
                 $time, c, exp.value, got.value);
        errors++;
      end
      if (exp.kind == EV_EXIT) begin
        exits_rcvd++;
      end
    end
  endtask

  function automatic logic queues_empty();
    logic empty;
    empty = 1'b1;
    for (int c = 0; c < NUM_CORES; c++) begin
      if (exp_q[c].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_i = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_i = 1'b0;
  endtask

  // Host acks after a random wait and holds ack a random time after req drops
  initial begin : host_responder
    int delay;
    forever begin
      @(negedge clk);
      if (ack_enable && host_req_o && !rst_i) begin
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1 host_ack_i = 1'b1;
        do @(negedge clk); while (host_req_o);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1 host_ack_i = 1'b0;
      end
    end
  end

  // Link monitor samples on the falling edge where outputs are settled
  always @(negedge clk) begin
    if (rst_i) begin
      req_q  = 1'b0;
      done_q = 1'b0;
    end else begin
      if (req_q && host_req_o && (host_event_o != event_q)) begin
        $display("Fail at %0t: host_event_o changed under req, expected %h got %h",
                 $time, event_q, host_event_o);
        errors++;
      end
      if (!req_q && host_req_o && host_ack_i) begin
        $display("Request at %0t rose while ack was still high", $time);
        errors++;
      end
      if (done_o && (exits_rcvd < NUM_CORES)) begin
        $display("Fail at %0t: done_o expected 0 got 1 (%0d exits seen)", $time, exits_rcvd);
        errors++;
      end
      if (done_q && !done_o) begin
        $display("Fail at %0t: done_o expected 1 got 0", $time);
        errors++;
      end
      if (host_req_o && !req_q) begin
        check_event(host_event_o);
      end
      req_q   = host_req_o;
      event_q = host_event_o;
      done_q  = done_o;
    end
  end

  initial begin
    rst_i      = 1'b1;
    trace_i    = '0;
    host_ack_i = 1'b0;
    ack_enable = 1'b1;
    for (int c = 0; c < NUM_CORES; c++) begin
      next_idx[c] = 0;
      r3_model[c] = '0;
      halted[c]   = 1'b0;
    end
    repeat (10) @(posedge clk);
    #1 rst_i = 1'b0;

    // Random traces on all cores are sparse enough that no queue fills
    errors_before = errors;
    events_seen   = 0;
    while (next_idx[0] < RECS_TOTAL || next_idx[1] < RECS_TOTAL ||
           next_idx[2] < RECS_TOTAL || next_idx[3] < RECS_TOTAL) begin
      @(posedge clk);
      #1;
      for (int c = 0; c < NUM_CORES; c++) begin
        trace_i[c] = '0;
        if (next_idx[c] < RECS_TOTAL && (($random(seed) & 15) == 0)) begin
          build_record(next_idx[c] == REC_PER_CORE,
                       (next_idx[c] > REC_PER_CORE) ? 50 : 10, rec);
          trace_i[c] = rec;
          model_record(c, rec);
          next_idx[c]++;
        end
      end
    end
    @(posedge clk);
    #1 trace_i = '0;
    while (!(queues_empty() && done_o)) @(negedge clk);
    repeat (50) @(negedge clk);
    checks++;
    if (!done_o) begin
      $display("Fail at %0t: done_o expected 1 got 0", $time);
      errors++;
    end
    if (overflow_o != '0) begin
      $display("Fail at %0t: overflow_o expected 0 got %b", $time, overflow_o);
      errors++;
    end
    $display("Test random_trace: %0d events checked, %0d errors",
             events_seen, errors - errors_before);

    // Overflow on core 0 with the host stalled
    ack_enable = 1'b0;
    apply_reset();
    errors_before = errors;
    events_seen   = 0;
    exits_rcvd    = 0;
    for (int c = 0; c < NUM_CORES; c++) begin
      r3_model[c] = '0;
      halted[c]   = 1'b0;
    end
    for (int k = 0; k < OVF_REPORTS; k++) begin
      tmp = $random(seed);
      @(posedge clk);
      #1;
      trace_i[0]        = '0;
      trace_i[0].valid  = 1'b1;
      trace_i[0].insn   = 32'h13000000;
      trace_i[0].wben   = 1'b1;
      trace_i[0].wbreg  = ARG_REG;
      trace_i[0].wbdata = {tmp[31:4], 4'(k)};
      model_record(0, trace_i[0]);
      @(posedge clk);
      #1;
      trace_i[0]       = '0;
      trace_i[0].valid = 1'b1;
      trace_i[0].insn  = NOP_REPORT;
      // Queue plus link register hold FIFO_DEPTH+1 events
      if (k <= FIFO_DEPTH) begin
        model_record(0, trace_i[0]);
      end
    end
    @(posedge clk);
    #1 trace_i = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    checks++;
    if (overflow_o != NUM_CORES'(1)) begin
      $display("Fail at %0t: overflow_o expected %b got %b",
               $time, NUM_CORES'(1), overflow_o);
      errors++;
    end
    ack_enable = 1'b1;
    while (!queues_empty()) @(negedge clk);
    repeat (50) @(negedge clk);
    $display("Test overflow: %0d events checked, %0d errors",
             events_seen, errors - errors_before);

    $display("Totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: trace_decode/trace_decode.sv
module trace_decode (
  input  logic                         clk,
  input  logic                         rst_i,
  input  logic [trace_pkg::CORE_W-1:0] core_id_i,
  input  trace_pkg::trace_exec_t       trace_i,
  output logic                         ev_valid_o,
  output trace_pkg::trace_event_t      ev_o
);

  import trace_pkg::*;

  typedef enum logic {
    RUN,
    HALTED
  } dec_state_e;

  dec_state_e  state_q;
  logic [31:0] r3_q;

  logic        active;
  logic        nop_hit;
  ev_kind_e    nop_kind;
  logic [31:0] nop_value;
  logic        r3_write;

  // Input is only looked at while the core has not exited
  assign active = trace_i.valid && (state_q == RUN);

  assign r3_write = active && trace_i.wben && (trace_i.wbreg == ARG_REG);

  // Match the instruction word against the control no-ops
  always_comb begin
    nop_hit  = 1'b0;
    nop_kind = EV_REPORT;
    case (trace_i.insn)
      NOP_EXIT: begin
        nop_hit  = 1'b1;
        nop_kind = EV_EXIT;
      end
      NOP_REPORT: begin
        nop_hit  = 1'b1;
        nop_kind = EV_REPORT;
      end
      NOP_PUTC: begin
        nop_hit  = 1'b1;
        nop_kind = EV_PUTC;
      end
      default: begin
        nop_hit  = 1'b0;
        nop_kind = EV_REPORT;
      end
    endcase
  end

  // A no-op sees r3 as it stood before its own cycle
  assign nop_value = (nop_kind == EV_PUTC) ? {24'h0, r3_q[7:0]} : r3_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q    <= RUN;
      ev_valid_o <= 1'b0;
      r3_q       <= '0;
    end else begin
      ev_valid_o <= active && nop_hit;
      if (r3_write) begin
        r3_q <= trace_i.wbdata;
      end
      // Exit freezes the decoder until reset
      if (active && nop_hit && (nop_kind == EV_EXIT)) begin
        state_q <= HALTED;
      end
    end
  end

  // Event payload
  always_ff @(posedge clk) begin
    if (active && nop_hit) begin
      ev_o.core  <= core_id_i;
      ev_o.kind  <= nop_kind;
      ev_o.value <= nop_value;
    end
  end

endmodule
